//--- design/bdLinkPkg.sv
package bdLinkPkg;

    // Word widths on the two directions of the link
    localparam int pin2CoreBits = 21;
    localparam int core2PinBits = 34;

    // Depth of each bridge buffer
    localparam int fifoDepth = 4;

    // Occupancy count must reach fifoDepth itself
    localparam int fifoCountBits = 3;

    // Word from the FPGA pins into the core
    typedef struct packed {
        // Destination tag inside the core
        logic [4:0]  route;
        logic [15:0] payload;
    } pinWord_t;

    // Word from the core out to the FPGA pins
    typedef struct packed {
        // Output tag chosen by the core
        logic [1:0]  route;
        logic [31:0] payload;
    } coreWord_t;

endpackage

//--- design/wordFifo.sv
`timescale 1ns/1ps

module wordFifo #(
    parameter type word_t = logic [7:0]
) (
    input  logic  clk,
    input  logic  rstN,
    input  logic  push,
    input  word_t pushData,
    input  logic  pop,
    output word_t popData,
    output logic  full,
    output logic  empty
);
    import bdLinkPkg::*;

    // Storage for the buffered words
    word_t mem [fifoDepth];

    logic [fifoCountBits-2:0] wrPtr;
    logic [fifoCountBits-2:0] rdPtr;
    logic [fifoCountBits-1:0] count;
    logic                     doPush;
    logic                     doPop;

    // Circular pointer step that wraps after the last entry
    function automatic logic [fifoCountBits-2:0] advance(input logic [fifoCountBits-2:0] ptr);
        logic [fifoCountBits-2:0] nextPtr;
        if (ptr == (fifoCountBits-1)'(fifoDepth - 1))
        begin
            nextPtr = '0;
        end
        else
        begin
            nextPtr = ptr + 1'b1;
        end
        return nextPtr;
    endfunction

    assign full  = (count == fifoCountBits'(fifoDepth));
    assign empty = (count == '0);

    // A pop on a full buffer frees the slot the push needs
    assign doPop  = pop && !empty;
    assign doPush = push && (!full || doPop);

    // Head word is shown combinationally
    assign popData = mem[rdPtr];

    always_ff @(posedge clk)
    begin
        if (doPush)
        begin
            mem[wrPtr] <= pushData;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end
        else
        begin
            if (doPush)
            begin
                wrPtr <= advance(wrPtr);
            end
            if (doPop)
            begin
                rdPtr <= advance(rdPtr);
            end
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- design/fpgaToBd.sv
`timescale 1ns/1ps

// Pin channel into the core
// Pins speak valid-acknowledge with the FPGA as active sender
// Core side is ready-valid with the bridge as passive sender
module fpgaToBd (
    input  logic                clk,
    input  logic                rstN,

    // Valid-acknowledge channel from the FPGA
    input  logic                pinValid,
    input  bdLinkPkg::pinWord_t pinData,
    output logic                pinAck,

    // Ready-valid toward the core
    output logic                coreValid,
    output bdLinkPkg::pinWord_t coreData,
    input  logic                coreReady
);
    import bdLinkPkg::*;

    logic ackNext;
    logic taken;
    logic corePop;
    logic fifoFull;
    logic fifoEmpty;

    // Acknowledge a fresh word only when the buffer has room
    // Room cannot shrink before the ack cycle, since no other push is pending
    assign ackNext = pinValid && !taken && !fifoFull;

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            pinAck <= 1'b0;
            taken  <= 1'b0;
        end
        else
        begin
            pinAck <= ackNext;

            // Held word already granted an ack
            if (ackNext)
            begin
                taken <= 1'b1;
            end
            else if (pinAck || !pinValid)
            begin
                // After the ack cycle any valid belongs to a new word
                taken <= 1'b0;
            end
        end
    end

    // Sender still holds the word during the ack cycle, so write it then
    assign corePop   = coreValid && coreReady;
    assign coreValid = !fifoEmpty;

    wordFifo #(
        .word_t(pinWord_t)
    ) pinFifo_i (
        .clk     (clk),
        .rstN    (rstN),
        .push    (pinAck),
        .pushData(pinData),
        .pop     (corePop),
        .popData (coreData),
        .full    (fifoFull),
        .empty   (fifoEmpty)
    );

endmodule

//--- design/bdToFpga.sv
`timescale 1ns/1ps

// Core channel out to the pins
// Core side is ready-valid with the bridge as active receiver
// Pins speak valid-acknowledge with the bridge as active sender
module bdToFpga (
    input  logic                 clk,
    input  logic                 rstN,

    // Ready-valid from the core
    input  logic                 bdValid,
    input  bdLinkPkg::coreWord_t bdData,
    output logic                 bdReady,

    // Valid-acknowledge toward the FPGA
    output logic                 fpgaValid,
    output bdLinkPkg::coreWord_t fpgaData,
    input  logic                 fpgaAck
);
    import bdLinkPkg::*;

    logic                     accept;
    logic                     deliver;
    logic                     fifoEmpty;
    logic [fifoCountBits-1:0] fillLevel;
    logic [fifoCountBits-1:0] fillNext;

    assign accept  = bdValid && bdReady;
    assign deliver = fpgaValid && fpgaAck;

    // Fill level after this cycle's transfers
    always_comb
    begin
        fillNext = fillLevel;
        if (accept && !deliver)
        begin
            fillNext = fillLevel + 1'b1;
        end
        else if (!accept && deliver)
        begin
            fillNext = fillLevel - 1'b1;
        end
    end

    // Ready comes from a register so the core never sees a combinational path
    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            fillLevel <= '0;
            bdReady   <= 1'b0;
        end
        else
        begin
            fillLevel <= fillNext;
            bdReady   <= (fillNext != fifoCountBits'(fifoDepth));
        end
    end

    // Head stays on the pins until the FPGA acknowledges it
    assign fpgaValid = !fifoEmpty;

    wordFifo #(
        .word_t(coreWord_t)
    ) coreFifo_i (
        .clk     (clk),
        .rstN    (rstN),
        .push    (accept),
        .pushData(bdData),
        .pop     (deliver),
        .popData (fpgaData),
        .full    (),
        .empty   (fifoEmpty)
    );

endmodule

//--- design/bdLinkTop.sv
`timescale 1ns/1ps

// Both link directions side by side on one clock
module bdLinkTop (
    input  logic                 clk,
    input  logic                 rstN,

    // FPGA to core channel
    input  logic                 pinValid,
    input  bdLinkPkg::pinWord_t  pinData,
    output logic                 pinAck,

    // Core receive side
    output logic                 coreValid,
    output bdLinkPkg::pinWord_t  coreData,
    input  logic                 coreReady,

    // Core send side
    input  logic                 bdValid,
    input  bdLinkPkg::coreWord_t bdData,
    output logic                 bdReady,

    // Core to FPGA channel
    output logic                 fpgaValid,
    output bdLinkPkg::coreWord_t fpgaData,
    input  logic                 fpgaAck
);

    fpgaToBd fpgaToBd_i (
        .clk      (clk),
        .rstN     (rstN),
        .pinValid (pinValid),
        .pinData  (pinData),
        .pinAck   (pinAck),
        .coreValid(coreValid),
        .coreData (coreData),
        .coreReady(coreReady)
    );

    // Independent of the inbound path, no shared state
    bdToFpga bdToFpga_i (
        .clk      (clk),
        .rstN     (rstN),
        .bdValid  (bdValid),
        .bdData   (bdData),
        .bdReady  (bdReady),
        .fpgaValid(fpgaValid),
        .fpgaData (fpgaData),
        .fpgaAck  (fpgaAck)
    );

endmodule

//--- testbench/bdLinkTb_asserts.sv
`timescale 1ns/1ps

// Handshake rules on the four channel ends of bdLinkTop
module bdLinkTb_asserts (
    input logic                 clk,
    input logic                 rstN,
    input logic                 pinValid,
    input logic                 pinAck,
    input logic                 coreValid,
    input bdLinkPkg::pinWord_t  coreData,
    input logic                 coreReady,
    input logic                 bdReady,
    input logic                 fpgaValid,
    input bdLinkPkg::coreWord_t fpgaData,
    input logic                 fpgaAck,
    input logic                 bdFull
);

    // Tally of failed rules for the testbench summary
    int failCount = 0;

    // An ack always answers a waiting word
    pinAckNeedsValid: assert property (@(posedge clk) disable iff (!rstN)
        pinAck |-> pinValid)
        else
        begin
            failCount++;
            $error("pinAck raised without pinValid");
        end

    fpgaAckNeedsValid: assert property (@(posedge clk) disable iff (!rstN)
        fpgaAck |-> fpgaValid)
        else
        begin
            failCount++;
            $error("fpgaAck raised without fpgaValid");
        end

    // Ack is a one cycle pulse
    pinAckPulse: assert property (@(posedge clk) disable iff (!rstN)
        pinAck |=> !pinAck)
        else
        begin
            failCount++;
            $error("pinAck held for more than one cycle");
        end

    // Bridge senders keep the word steady until it is taken
    coreHold: assert property (@(posedge clk) disable iff (!rstN)
        (coreValid && !coreReady) |=> (coreValid && $stable(coreData)))
        else
        begin
            failCount++;
            $error("core word changed while stalled");
        end

    fpgaHold: assert property (@(posedge clk) disable iff (!rstN)
        (fpgaValid && !fpgaAck) |=> (fpgaValid && $stable(fpgaData)))
        else
        begin
            failCount++;
            $error("fpga word changed before its ack");
        end

    // Outbound buffer never offers room it does not have
    noReadyWhenFull: assert property (@(posedge clk) disable iff (!rstN)
        bdFull |-> !bdReady)
        else
        begin
            failCount++;
            $error("bdReady high with the buffer full");
        end

endmodule

//--- testbench/bdLinkTb.sv
`timescale 1ns/1ps

module bdLinkTb;
    import bdLinkPkg::*;

    localparam int wordCount      = 200;
    localparam int watchdogCycles = 2 * wordCount * 30;

    logic      clk = 1'b0;
    logic      rstN;
    logic      pinValid;
    pinWord_t  pinData;
    logic      pinAck;
    logic      coreValid;
    pinWord_t  coreData;
    logic      coreReady;
    logic      bdValid;
    coreWord_t bdData;
    logic      bdReady;
    logic      fpgaValid;
    coreWord_t fpgaData;
    logic      fpgaAck;

    int seed = 32'h5a2987f9;

    // Reference queues hold words accepted but not yet delivered
    pinWord_t  pinQ[$];
    coreWord_t bdQ[$];
    pinWord_t  expCore;
    coreWord_t expFpga;
    logic      coreOrphan = 1'b0;
    logic      fpgaOrphan = 1'b0;
    int        pinPending = 0;
    int        bdPending = 0;
    int        coreCount = 0;
    int        fpgaCount = 0;

    int coreErrors = 0;
    int fpgaErrors = 0;
    int otherErrors = 0;
    int protoErrors = 0;

    always #4 clk = ~clk;

    bdLinkTop bdLinkTop_i (
        .clk      (clk),
        .rstN     (rstN),
        .pinValid (pinValid),
        .pinData  (pinData),
        .pinAck   (pinAck),
        .coreValid(coreValid),
        .coreData (coreData),
        .coreReady(coreReady),
        .bdValid  (bdValid),
        .bdData   (bdData),
        .bdReady  (bdReady),
        .fpgaValid(fpgaValid),
        .fpgaData (fpgaData),
        .fpgaAck  (fpgaAck)
    );

    bind bdLinkTop bdLinkTb_asserts protocolChecks_i (
        .clk      (clk),
        .rstN     (rstN),
        .pinValid (pinValid),
        .pinAck   (pinAck),
        .coreValid(coreValid),
        .coreData (coreData),
        .coreReady(coreReady),
        .bdReady  (bdReady),
        .fpgaValid(fpgaValid),
        .fpgaData (fpgaData),
        .fpgaAck  (fpgaAck),
        .bdFull   (bdToFpga_i.coreFifo_i.full)
    );

    function automatic int pickDelay(input int maxCycles);
        return $unsigned($random(seed)) % (maxCycles + 1);
    endfunction

    // Leaves the caller just after a rising edge
    task automatic idleCycles(input int count);
        if (count > 0)
        begin
            repeat (count) @(posedge clk);
            #1;
        end
    endtask

    task automatic sendPinWords();
        for (int n = 0; n < wordCount; n++)
        begin
            if (pickDelay(5) > 0)
            begin
                pinValid = 1'b0;
                idleCycles(pickDelay(4) + 1);
            end
            pinValid = 1'b1;
            pinData  = pin2CoreBits'($random(seed));
            do
            begin
                @(negedge clk);
            end
            while (!pinAck);
            @(posedge clk);
            #1;
        end
        pinValid = 1'b0;
    endtask

    task automatic sendBdWords();
        for (int n = 0; n < wordCount; n++)
        begin
            if (pickDelay(5) > 0)
            begin
                bdValid = 1'b0;
                idleCycles(pickDelay(4) + 1);
            end
            bdValid = 1'b1;
            bdData  = core2PinBits'({$random(seed), $random(seed)});
            do
            begin
                @(negedge clk);
            end
            while (!bdReady);
            @(posedge clk);
            #1;
        end
        bdValid = 1'b0;
    endtask

    task automatic drainCore();
        // Long opening stall fills the inbound buffer
        coreReady = 1'b0;
        idleCycles(24);
        while (coreCount < wordCount)
        begin
            coreReady = 1'b0;
            idleCycles(pickDelay(20));
            coreReady = 1'b1;
            do
            begin
                @(negedge clk);
            end
            while (!coreValid);
            @(posedge clk);
            #1;
        end
        coreReady = 1'b0;
    endtask

    task automatic ackFpgaWords();
        fpgaAck = 1'b0;
        idleCycles(24);
        while (fpgaCount < wordCount)
        begin
            do
            begin
                @(negedge clk);
            end
            while (!fpgaValid);
            @(posedge clk);
            #1;
            idleCycles(pickDelay(20));
            fpgaAck = 1'b1;
            @(posedge clk);
            #1;
            fpgaAck = 1'b0;
        end
    endtask

    // Transfers are recorded mid cycle where every signal is settled
    always @(negedge clk)
    begin
        if (rstN)
        begin
            coreOrphan = 1'b0;
            fpgaOrphan = 1'b0;
            if (coreValid && coreReady)
            begin
                coreCount++;
                if (pinQ.size() > 0)
                    expCore = pinQ.pop_front();
                else
                    coreOrphan = 1'b1;
            end
            if (fpgaValid && fpgaAck)
            begin
                fpgaCount++;
                if (bdQ.size() > 0)
                    expFpga = bdQ.pop_front();
                else
                    fpgaOrphan = 1'b1;
            end
            if (pinAck)
                pinQ.push_back(pinData);
            if (bdValid && bdReady)
                bdQ.push_back(bdData);
            pinPending = pinQ.size();
            bdPending  = bdQ.size();
        end
    end

    coreOrder: assert property (@(posedge clk) disable iff (!rstN)
        (coreValid && coreReady) |-> (coreData == expCore))
        else
        begin
            coreErrors++;
            $display("error: coreData expected %h got %h", expCore, $sampled(coreData));
        end

    fpgaOrder: assert property (@(posedge clk) disable iff (!rstN)
        (fpgaValid && fpgaAck) |-> (fpgaData == expFpga))
        else
        begin
            fpgaErrors++;
            $display("error: fpgaData expected %h got %h", expFpga, $sampled(fpgaData));
        end

    coreNoExtra: assert property (@(posedge clk) disable iff (!rstN) !coreOrphan)
        else
        begin
            coreErrors++;
            $display("core received a word that was never sent");
        end

    fpgaNoExtra: assert property (@(posedge clk) disable iff (!rstN) !fpgaOrphan)
        else
        begin
            fpgaErrors++;
            $display("pins received a word that was never sent");
        end

    // Words in flight can never exceed one buffer
    pinBackPressure: assert property (@(posedge clk) disable iff (!rstN)
        pinPending <= fifoDepth)
        else
        begin
            otherErrors++;
            $display("more pin words accepted than the buffer holds");
        end

    bdBackPressure: assert property (@(posedge clk) disable iff (!rstN)
        bdPending <= fifoDepth)
        else
        begin
            otherErrors++;
            $display("more bd words accepted than the buffer holds");
        end

    resetQuiet: assert property (@(posedge clk)
        !rstN |=> !(pinAck || coreValid || fpgaValid))
        else
        begin
            otherErrors++;
            $display("outputs active during or right after reset");
        end

    initial
    begin
        repeat (watchdogCycles) @(posedge clk);
        $display("timeout: words still pending");
        $display("Test failures found");
        $finish;
    end

    initial
    begin
        rstN      = 1'b0;
        pinValid  = 1'b0;
        pinData   = '0;
        coreReady = 1'b0;
        bdValid   = 1'b0;
        bdData    = '0;
        fpgaAck   = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rstN = 1'b1;

        fork
            sendPinWords();
            drainCore();
            sendBdWords();
            ackFpgaWords();
        join
        repeat (4) @(posedge clk);

        assert (pinQ.size() == 0)
        else
        begin
            otherErrors++;
            $display("pin words never reached the core");
        end
        assert (bdQ.size() == 0)
        else
        begin
            otherErrors++;
            $display("bd words never reached the pins");
        end
        assert (coreCount == wordCount)
        else
        begin
            otherErrors++;
            $display("error: coreCount expected %h got %h", wordCount, coreCount);
        end
        assert (fpgaCount == wordCount)
        else
        begin
            otherErrors++;
            $display("error: fpgaCount expected %h got %h", wordCount, fpgaCount);
        end

        protoErrors = bdLinkTop_i.protocolChecks_i.failCount;
        $display("errors: pins-to-core %0d, core-to-pins %0d, other %0d, protocol %0d",
                 coreErrors, fpgaErrors, otherErrors, protoErrors);
        if (coreErrors + fpgaErrors + otherErrors + protoErrors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

//--- vlog.f
design/bdLinkPkg.sv
design/wordFifo.sv
design/fpgaToBd.sv
design/bdToFpga.sv
design/bdLinkTop.sv
testbench/bdLinkTb_asserts.sv
testbench/bdLinkTb.sv

//--- Bender.yml
package:
  name: bdLink

sources:
  - files:
      - design/bdLinkPkg.sv
      - design/wordFifo.sv
      - design/fpgaToBd.sv
      - design/bdToFpga.sv
      - design/bdLinkTop.sv
  - target: simulation
    files:
      - testbench/bdLinkTb_asserts.sv
      - testbench/bdLinkTb.sv
